// ==== all.f ====
+incdir+hw
hw/lsqPkg.sv
hw/stqPointers.sv
hw/stqEntry.sv
hw/stqReadout.sv
hw/storeQueue.sv
testbench/storeQueueTb.sv

// ==== hw/lsqPkg.sv ====
/* LSU store queue types
   word address, data, index, phase tag and occupancy */
`include "lsq_macros.svh"

package lsqPkg;

  // word address from the address generator
  typedef logic [`ADDR_W-1:0] addr_t;

  // one store data word
  typedef logic [`DATA_W-1:0] data_t;

  // entry index into the queue
  typedef logic [`SQ_LOG-1:0] stqIdx_t;

  // index plus phase bit on top, phase flips on every wrap
  // so tags repeat after twice the depth
  typedef logic [`SQ_LOG:0] stqTag_t;

  // occupancy 0..SQ_ENTRIES, needs the extra bit
  typedef logic [`SQ_LOG:0] stqCount_t;

endpackage

// ==== hw/lsq_macros.svh ====
/* Store queue sizing macros
   depth, index width and word widths shared by the LSU store side */
`ifndef LSQ_MACROS_SVH
`define LSQ_MACROS_SVH

// queue depth, keep a power of two
`define SQ_ENTRIES 8

// entry index width, log2 of depth
`define SQ_LOG 3

// word address width
`define ADDR_W 32

// store data width, whole words only
`define DATA_W 32

`endif

// ==== hw/storeQueue.sv ====
/* Store queue top
   pointer block, entry array and readout for store-to-load forwarding */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module storeQueue (
  input  logic              clk,
  input  logic              reset,
  input  logic              dispStValid_i,
  output lsqPkg::stqTag_t   stTag_o,        // tail tag, same cycle
  input  logic              stExecValid_i,
  input  lsqPkg::stqTag_t   stExecTag_i,
  input  lsqPkg::addr_t     stAddr_i,
  input  lsqPkg::data_t     stData_i,
  input  logic              ldValid_i,
  input  lsqPkg::addr_t     ldAddr_i,
  input  lsqPkg::stqTag_t   ldLastSt_i,
  output logic              ldRespValid_o,
  output logic              ldFwdHit_o,
  output lsqPkg::data_t     ldFwdData_o,
  input  logic              commitSt_i,
  output logic              memStValid_o,
  output lsqPkg::addr_t     memStAddr_o,
  output lsqPkg::data_t     memStData_o,
  output lsqPkg::stqCount_t stqCount_o
);

  lsqPkg::stqIdx_t        headIdx;
  logic [`SQ_ENTRIES-1:0] allocVec;
  logic [`SQ_ENTRIES-1:0] addrWrVec;
  logic [`SQ_ENTRIES-1:0] releaseVec;
  logic [`SQ_ENTRIES-1:0] fwdMatch;
  logic [`SQ_ENTRIES-1:0] addrValid;
  lsqPkg::addr_t          entryAddr [`SQ_ENTRIES];
  lsqPkg::data_t          entryData [`SQ_ENTRIES];

  stqPointers pointers (
    .clk            (clk),
    .reset          (reset),
    .dispStValid_i  (dispStValid_i),
    .stExecValid_i  (stExecValid_i),
    .stExecTag_i    (stExecTag_i),
    .commitSt_i     (commitSt_i),
    .tailTag_o      (stTag_o),
    .headIdx_o      (headIdx),
    .count_o        (stqCount_o),
    .alloc_o        (allocVec),
    .addrWr_o       (addrWrVec),
    .release_o      (releaseVec)
  );

  // one entry per slot, tail phase goes to whichever slot allocates
  for (genvar i = 0; i < `SQ_ENTRIES; i++)
  begin : gEntry
    stqEntry #(
      .ENTRY_IDX (i)
    ) entry (
      .clk          (clk),
      .reset        (reset),
      .alloc_i      (allocVec[i]),
      .allocPhase_i (stTag_o[`SQ_LOG]),
      .addrWr_i     (addrWrVec[i]),
      .release_i    (releaseVec[i]),
      .addr_i       (stAddr_i),
      .data_i       (stData_i),
      .ldAddr_i     (ldAddr_i),
      .ldLastSt_i   (ldLastSt_i),
      .fwdMatch_o   (fwdMatch[i]),
      .entryAddr_o  (entryAddr[i]),
      .entryData_o  (entryData[i]),
      .addrValid_o  (addrValid[i])
    );
  end

  stqReadout readout (
    .clk            (clk),
    .reset          (reset),
    .ldValid_i      (ldValid_i),
    .ldLastSt_i     (ldLastSt_i),
    .fwdMatch_i     (fwdMatch),
    .entryAddr_i    (entryAddr),
    .entryData_i    (entryData),
    .addrValid_i    (addrValid),
    .headIdx_i      (headIdx),
    .commitSt_i     (commitSt_i),
    .ldRespValid_o  (ldRespValid_o),
    .ldFwdHit_o     (ldFwdHit_o),
    .ldFwdData_o    (ldFwdData_o),
    .memStValid_o   (memStValid_o),
    .memStAddr_o    (memStAddr_o),
    .memStData_o    (memStData_o)
  );

endmodule

// ==== hw/stqEntry.sv ====
/* Store queue entry
   holds one store, compares its address and age against a broadcast load */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module stqEntry #(
  parameter int ENTRY_IDX = 0  // fixed slot position in the queue
) (
  input  logic            clk,
  input  logic            reset,
  input  logic            alloc_i,       // dispatch into this slot
  input  logic            allocPhase_i,  // tail phase at dispatch
  input  logic            addrWr_i,      // agen write for this slot
  input  logic            release_i,     // commit frees this slot
  input  lsqPkg::addr_t   addr_i,
  input  lsqPkg::data_t   data_i,
  input  lsqPkg::addr_t   ldAddr_i,      // load broadcast
  input  lsqPkg::stqTag_t ldLastSt_i,    // youngest store older than load
  output logic            fwdMatch_o,
  output lsqPkg::addr_t   entryAddr_o,
  output lsqPkg::data_t   entryData_o,
  output logic            addrValid_o
);

  logic            valid;
  logic            addrValid;
  logic            phase;     // phase captured at alloc
  lsqPkg::addr_t   addr;
  lsqPkg::data_t   data;
  lsqPkg::stqTag_t entryTag;
  lsqPkg::stqTag_t ageDist;   // load's last store minus this entry
  logic            notYounger;

  // flags
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      valid     <= 1'b0;
      addrValid <= 1'b0;
    end
    else
    begin
      if (release_i)
      begin
        valid     <= 1'b0;
        addrValid <= 1'b0;
      end
      if (alloc_i)
      begin
        valid     <= 1'b1;
        addrValid <= 1'b0;  // address arrives later from agen
      end
      if (addrWr_i)
        addrValid <= 1'b1;
    end
  end

  // payload, only meaningful while valid
  always_ff @(posedge clk)
  begin
    if (alloc_i)
      phase <= allocPhase_i;
    if (addrWr_i)
    begin
      addr <= addr_i;
      data <= data_i;
    end
  end

  // rebuild this store's full tag from slot and phase
  assign entryTag   = {phase, lsqPkg::stqIdx_t'(ENTRY_IDX)};
  assign ageDist    = ldLastSt_i - entryTag;  // mod 2*depth
  assign notYounger = ageDist < lsqPkg::stqTag_t'(`SQ_ENTRIES);

  // same-cycle agen write is not seen, addr is registered
  assign fwdMatch_o  = valid & addrValid & (addr == ldAddr_i) & notYounger;
  assign entryAddr_o = addr;
  assign entryData_o = data;
  assign addrValid_o = addrValid;

  // agen may only write a slot that dispatch already filled
  assert property (@(posedge clk) disable iff (reset)
    addrWr_i |-> valid)
    else $error("address write to free store entry %0d", ENTRY_IDX);

endmodule

// ==== hw/stqPointers.sv ====
/* Store queue pointer block
   head/tail tags, occupancy and one-hot per-entry event strobes */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module stqPointers (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    dispStValid_i,  // one store dispatched
  input  logic                    stExecValid_i,  // agen writes addr/data
  input  lsqPkg::stqTag_t         stExecTag_i,    // tag of executed store
  input  logic                    commitSt_i,     // head store retires
  output lsqPkg::stqTag_t         tailTag_o,      // tag for next dispatch
  output lsqPkg::stqIdx_t         headIdx_o,      // oldest entry
  output lsqPkg::stqCount_t       count_o,
  output logic [`SQ_ENTRIES-1:0]  alloc_o,
  output logic [`SQ_ENTRIES-1:0]  addrWr_o,
  output logic [`SQ_ENTRIES-1:0]  release_o
);

  lsqPkg::stqTag_t   headTag;
  lsqPkg::stqTag_t   tailTag;
  lsqPkg::stqCount_t count;
  lsqPkg::stqTag_t   execOffset;  // exec tag distance from head

  // pointers and count, tags carry the phase bit in the msb
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      headTag <= '0;
      tailTag <= '0;
      count   <= '0;
    end
    else
    begin
      if (dispStValid_i)
        tailTag <= tailTag + lsqPkg::stqTag_t'(1);  // wraps into phase bit
      if (commitSt_i)
        headTag <= headTag + lsqPkg::stqTag_t'(1);
      case ({dispStValid_i, commitSt_i})
        2'b10:   count <= count + lsqPkg::stqCount_t'(1);
        2'b01:   count <= count - lsqPkg::stqCount_t'(1);
        default: count <= count;  // both or neither, no change
      endcase
    end
  end

  // tag is usable by dispatch in the same cycle
  assign tailTag_o = tailTag;
  assign headIdx_o = headTag[`SQ_LOG-1:0];
  assign count_o   = count;

  // one-hot event decode, one strobe per entry
  always_comb
  begin
    alloc_o   = '0;
    addrWr_o  = '0;
    release_o = '0;
    alloc_o[tailTag[`SQ_LOG-1:0]]     = dispStValid_i;
    addrWr_o[stExecTag_i[`SQ_LOG-1:0]] = stExecValid_i;
    release_o[headTag[`SQ_LOG-1:0]]   = commitSt_i;
  end

  assign execOffset = stExecTag_i - headTag;

  // no back-pressure, dispatch must never hit a full queue
  assert property (@(posedge clk) disable iff (reset)
    dispStValid_i |-> count != lsqPkg::stqCount_t'(`SQ_ENTRIES))
    else $error("store dispatched into a full queue");

  // commit must have something at the head
  assert property (@(posedge clk) disable iff (reset)
    commitSt_i |-> count != '0)
    else $error("store commit on an empty queue");

  // agen tag must name a live store, phase included
  assert property (@(posedge clk) disable iff (reset)
    stExecValid_i |-> execOffset < count)
    else $error("store executed with a stale or unallocated tag");

endmodule

// ==== hw/stqReadout.sv ====
/* Store queue readout
   youngest-older forwarding select, load response and commit write */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module stqReadout (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   ldValid_i,
  input  lsqPkg::stqTag_t        ldLastSt_i,
  input  logic [`SQ_ENTRIES-1:0] fwdMatch_i,   // per-entry match, age filtered
  input  lsqPkg::addr_t          entryAddr_i [`SQ_ENTRIES],
  input  lsqPkg::data_t          entryData_i [`SQ_ENTRIES],
  input  logic [`SQ_ENTRIES-1:0] addrValid_i,
  input  lsqPkg::stqIdx_t        headIdx_i,
  input  logic                   commitSt_i,
  output logic                   ldRespValid_o,
  output logic                   ldFwdHit_o,
  output lsqPkg::data_t          ldFwdData_o,
  output logic                   memStValid_o,
  output lsqPkg::addr_t          memStAddr_o,
  output lsqPkg::data_t          memStData_o
);

  lsqPkg::stqIdx_t lastIdx;  // slot of the load's last older store
  lsqPkg::stqIdx_t scanIdx;
  lsqPkg::stqIdx_t fwdSel;   // winning slot
  logic            fwdHit;

  assign lastIdx = ldLastSt_i[`SQ_LOG-1:0];

  // walk backward from last older store, first match is the youngest one
  // entries younger than the load were already masked in the entry
  always_comb
  begin
    fwdHit  = 1'b0;
    fwdSel  = '0;
    scanIdx = '0;
    for (int k = 0; k < `SQ_ENTRIES; k++)
    begin
      scanIdx = lastIdx - lsqPkg::stqIdx_t'(k);  // wraps circularly
      if (!fwdHit && fwdMatch_i[scanIdx])
      begin
        fwdHit = 1'b1;
        fwdSel = scanIdx;
      end
    end
  end

  // response and commit strobes
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ldRespValid_o <= 1'b0;
      ldFwdHit_o    <= 1'b0;
      memStValid_o  <= 1'b0;
    end
    else
    begin
      ldRespValid_o <= ldValid_i;           // exactly one cycle later
      ldFwdHit_o    <= ldValid_i & fwdHit;
      memStValid_o  <= commitSt_i;
    end
  end

  // response and write payload
  always_ff @(posedge clk)
  begin
    if (ldValid_i)
      ldFwdData_o <= fwdHit ? entryData_i[fwdSel] : '0;  // miss gives zero
    if (commitSt_i)
    begin
      memStAddr_o <= entryAddr_i[headIdx_i];
      memStData_o <= entryData_i[headIdx_i];
    end
  end

  // head must have its address before it can retire
  assert property (@(posedge clk) disable iff (reset)
    commitSt_i |-> addrValid_i[headIdx_i])
    else $error("committed store %0d has no address", headIdx_i);

endmodule

// ==== run.sh ====
#!/bin/sh
# build the store queue testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --assert --timescale 1ns/1ps -f all.f --top-module storeQueueTb \
  -o storeQueueSim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/storeQueueSim > sim.log 2>&1
cat sim.log
grep -qx "Test OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// ==== testbench/storeQueueTb.sv ====
/* Store queue testbench
   table-driven dispatch, forwarding, commit and wraparound checks */
`timescale 1ns/1ps
`include "lsq_macros.svh"

module storeQueueTb;

  typedef enum int {opIdle, opDisp, opExec, opLoad, opCommit} rowOp_e;

  localparam int RespTimeout = 8;  // cycles allowed for a response pulse

  logic              clk;
  logic              reset;
  logic              dispStValid_i;
  lsqPkg::stqTag_t   stTag_o;
  logic              stExecValid_i;
  lsqPkg::stqTag_t   stExecTag_i;
  lsqPkg::addr_t     stAddr_i;
  lsqPkg::data_t     stData_i;
  logic              ldValid_i;
  lsqPkg::addr_t     ldAddr_i;
  lsqPkg::stqTag_t   ldLastSt_i;
  logic              ldRespValid_o;
  logic              ldFwdHit_o;
  lsqPkg::data_t     ldFwdData_o;
  logic              commitSt_i;
  logic              memStValid_o;
  lsqPkg::addr_t     memStAddr_o;
  lsqPkg::data_t     memStData_o;
  lsqPkg::stqCount_t stqCount_o;

  // stimulus table with one slot per row
  rowOp_e            opQ[$];
  lsqPkg::stqTag_t   tagQ[$];   // dispatch tag, exec tag or load's last store
  lsqPkg::addr_t     addrQ[$];  // exec/load addr, or expected write addr
  lsqPkg::data_t     dataQ[$];  // exec data, expected fwd or write data
  logic              hitQ[$];
  lsqPkg::stqCount_t cntQ[$];   // occupancy after the row

  // reference model of live stores in program order
  lsqPkg::stqTag_t   mTag[$];
  lsqPkg::addr_t     mAddr[$];
  lsqPkg::data_t     mData[$];
  logic              mKnown[$];
  lsqPkg::stqTag_t   mTail;
  lsqPkg::addr_t     addrPool [4];  // small pool so loads actually hit
  int                seed;

  storeQueue DUT (.*);

  initial clk = 1'b0;
  always #4 clk = ~clk;  // 8 ns period

  task automatic stopRun();
    $display("Test FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic reportMismatch(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
    $display("[ERROR] %0t %s got %h expected %h", $time, name, got, exp);
    stopRun();
  endtask

  task automatic checkData(input string name, input lsqPkg::data_t got, input lsqPkg::data_t exp);
    if (got !== exp)
      reportMismatch(name, got, exp);
  endtask

  task automatic checkAddr(input string name, input lsqPkg::addr_t got, input lsqPkg::addr_t exp);
    if (got !== exp)
      reportMismatch(name, got, exp);
  endtask

  task automatic checkTag(input string name, input lsqPkg::stqTag_t got,
                          input lsqPkg::stqTag_t exp);
    if (got !== exp)
      reportMismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic checkCount(input string name, input lsqPkg::stqCount_t got,
                            input lsqPkg::stqCount_t exp);
    if (got !== exp)
      reportMismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
      reportMismatch(name, 32'(got), 32'(exp));
  endtask

  task automatic stepCycle();
    @(posedge clk);
    #1;  // drive just after the edge
  endtask

  task automatic idleInputs();
    dispStValid_i = 1'b0;
    stExecValid_i = 1'b0;
    stExecTag_i   = '0;
    stAddr_i      = '0;
    stData_i      = '0;
    ldValid_i     = 1'b0;
    ldAddr_i      = '0;
    ldLastSt_i    = '0;
    commitSt_i    = 1'b0;
  endtask

  // request already sampled so the response is due at this edge
  task automatic waitForPulse(input logic isMem);
    int latency;
    latency = 1;
    while ((isMem ? memStValid_o : ldRespValid_o) !== 1'b1)
    begin
      if (latency >= RespTimeout)
      begin
        $display("no %s pulse within %0d cycles", isMem ? "memory write" : "load response",
                 RespTimeout);
        stopRun();
      end
      stepCycle();
      latency++;
    end
    if (latency != 1)
    begin
      $display("response arrived %0d cycles after the request instead of 1", latency);
      stopRun();
    end
  endtask

  task automatic addRow(input rowOp_e op, input int tag, input lsqPkg::addr_t addr,
                        input lsqPkg::data_t data, input int hit, input int cnt);
    opQ.push_back(op);
    tagQ.push_back(lsqPkg::stqTag_t'(tag));
    addrQ.push_back(addr);
    dataQ.push_back(data);
    hitQ.push_back(hit != 0);
    cntQ.push_back(lsqPkg::stqCount_t'(cnt));
  endtask

  task automatic dispatchStore();
    mTag.push_back(mTail);
    mAddr.push_back('0);
    mData.push_back('0);
    mKnown.push_back(1'b0);
    addRow(opDisp, int'(mTail), '0, '0, 0, mTag.size());
    mTail = mTail + lsqPkg::stqTag_t'(1);  // wraps through the phase bit
  endtask

  task automatic executeStore(input int pos);
    int pick;
    pick        = $random(seed) & 3;
    mAddr[pos]  = addrPool[pick[1:0]];
    mData[pos]  = lsqPkg::data_t'($random(seed));
    mKnown[pos] = 1'b1;
    addRow(opExec, int'(mTag[pos]), mAddr[pos], mData[pos], 0, mTag.size());
  endtask

  task automatic issueLoad();
    int            pick;
    int            last;
    logic          hit;
    lsqPkg::addr_t addr;
    lsqPkg::data_t data;
    pick = $random(seed) & 3;
    addr = addrPool[pick[1:0]];
    last = ($random(seed) & 32'h7fffffff) % mTag.size();  // youngest older store
    hit  = 1'b0;
    data = '0;
    for (int i = last; i >= 0; i--)
    begin
      if (!hit && mKnown[i] && mAddr[i] == addr)  // youngest known match
      begin
        hit  = 1'b1;
        data = mData[i];
      end
    end
    addRow(opLoad, int'(mTag[last]), addr, data, int'(hit), mTag.size());
  endtask

  task automatic commitStore();
    addRow(opCommit, 0, mAddr[0], mData[0], 0, mTag.size() - 1);
    void'(mTag.pop_front());
    void'(mAddr.pop_front());
    void'(mData.pop_front());
    void'(mKnown.pop_front());
  endtask

  task automatic applyRow(input int r);
    case (opQ[r])
      opDisp:
      begin
        checkTag("stTag_o", stTag_o, tagQ[r]);  // tail tag valid before dispatch
        dispStValid_i = 1'b1;
      end
      opExec:
      begin
        stExecValid_i = 1'b1;
        stExecTag_i   = tagQ[r];
        stAddr_i      = addrQ[r];
        stData_i      = dataQ[r];
      end
      opLoad:
      begin
        ldValid_i  = 1'b1;
        ldAddr_i   = addrQ[r];
        ldLastSt_i = tagQ[r];
      end
      opCommit: commitSt_i = 1'b1;
      default: ;  // idle row
    endcase
    stepCycle();
    idleInputs();
    if (opQ[r] == opLoad)
    begin
      waitForPulse(1'b0);
      checkBit("ldFwdHit_o", ldFwdHit_o, hitQ[r]);
      if (hitQ[r])
        checkData("ldFwdData_o", ldFwdData_o, dataQ[r]);
    end
    else
      checkBit("ldRespValid_o", ldRespValid_o, 1'b0);
    if (opQ[r] == opCommit)
    begin
      waitForPulse(1'b1);
      checkAddr("memStAddr_o", memStAddr_o, addrQ[r]);
      checkData("memStData_o", memStData_o, dataQ[r]);
    end
    else
      checkBit("memStValid_o", memStValid_o, 1'b0);
    checkCount("stqCount_o", stqCount_o, cntQ[r]);
  endtask

  initial
  begin
    seed = 32'he7e8cd7c;
    // four fixed stores and loads around 0x100 with tag 3 younger
    for (int i = 0; i < 4; i++)
      addRow(opDisp, i, '0, '0, 0, i + 1);
    addRow(opExec, 0, 32'h100, 32'hAAAA0000, 0, 4);
    addRow(opExec, 1, 32'h100, 32'hBBBB1111, 0, 4);
    addRow(opExec, 3, 32'h100, 32'hDDDD3333, 0, 4);
    addRow(opLoad, 2, 32'h100, 32'hBBBB1111, 1, 4);  // tag 1 is the youngest known match
    addRow(opLoad, 0, 32'h100, 32'hAAAA0000, 1, 4);
    addRow(opLoad, 3, 32'h200, 32'h0, 0, 4);
    addRow(opExec, 2, 32'h100, 32'hCCCC2222, 0, 4);
    addRow(opLoad, 2, 32'h100, 32'hCCCC2222, 1, 4);
    addRow(opLoad, 3, 32'h100, 32'hDDDD3333, 1, 4);
    addRow(opDisp, 4, '0, '0, 0, 5);
    addRow(opLoad, 4, 32'h300, 32'h0, 0, 5);         // only match still unknown
    addRow(opExec, 4, 32'h300, 32'hEEEE4444, 0, 5);
    addRow(opLoad, 4, 32'h300, 32'hEEEE4444, 1, 5);
    addRow(opLoad, 3, 32'h300, 32'h0, 0, 5);         // matching store is younger
    addRow(opCommit, 0, 32'h100, 32'hAAAA0000, 0, 4);
    addRow(opCommit, 0, 32'h100, 32'hBBBB1111, 0, 3);
    addRow(opCommit, 0, 32'h100, 32'hCCCC2222, 0, 2);
    addRow(opCommit, 0, 32'h100, 32'hDDDD3333, 0, 1);
    addRow(opCommit, 0, 32'h300, 32'hEEEE4444, 0, 0);
    addRow(opLoad, 3, 32'h100, 32'h0, 0, 0);         // released stores give no data
    addRow(opIdle, 0, '0, '0, 0, 0);
    mTail = lsqPkg::stqTag_t'(5);
    repeat (4) dispatchStore();                      // tag 8 takes slot 0 again
    addRow(opLoad, 8, 32'h100, 32'h0, 0, 4);         // slot 0 keeps its old 0x100 unwritten
    // random rows from the model wrap the tags several times
    for (int i = 0; i < 4; i++)
      addrPool[i] = lsqPkg::addr_t'($random(seed));
    for (int round = 0; round < 4; round++)
    begin
      while (mTag.size() < `SQ_ENTRIES)
        dispatchStore();                             // fill to full
      for (int i = 0; i < mTag.size(); i++)
        if (($random(seed) & 1) != 0)
          executeStore(i);
      repeat (3) issueLoad();
      for (int i = 0; i < mTag.size(); i++)
        if (!mKnown[i])
          executeStore(i);
      repeat (3) issueLoad();
      repeat (3 + (($random(seed) & 32'h7fffffff) % 4)) commitStore();
      repeat (2) issueLoad();
    end
    while (mTag.size() > 0)
      commitStore();

    idleInputs();
    reset = 1'b1;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
    checkCount("stqCount_o", stqCount_o, '0);
    checkBit("memStValid_o", memStValid_o, 1'b0);
    checkBit("ldRespValid_o", ldRespValid_o, 1'b0);
    for (int r = 0; r < opQ.size(); r++)
      applyRow(r);
    $display("%0d table rows applied", opQ.size());
    $display("Test OK");
    $finish;
  end

endmodule
